//--- src/neoPixelPkg.sv
package neoPixelPkg;

  // Frame buffer geometry
  localparam int bufferEnd  = 1023;   // Last byte address of the frame buffer
  localparam int bufferBits = 10;     // Address width that reaches bufferEnd
  localparam int regMaxBits = 13;
  localparam int geomBits   = 14;     // Width and height registers, counted from 1

  // Register indexes, decoded from busAddr[3:0]
  localparam logic [3:0] regMaxLo    = 4'd0;
  localparam logic [3:0] regMaxHi    = 4'd1;
  localparam logic [3:0] regCtrl     = 4'd2;
  localparam logic [3:0] regState    = 4'd3;
  localparam logic [3:0] regWidthLo  = 4'd5;
  localparam logic [3:0] regWidthHi  = 4'd6;
  localparam logic [3:0] regHeightLo = 4'd7;
  localparam logic [3:0] regHeightHi = 4'd8;

  // Bit positions inside regCtrl
  localparam int ctrlInit  = 0;
  localparam int ctrlLimit = 1;
  localparam int ctrlRun   = 2;
  localparam int ctrlLoop  = 3;
  localparam int ctrlWide  = 4;   // Set for 32-bit pixels, clear skips every fourth byte

  // Waveform timing in busClk cycles
  localparam int tBit   = 10;
  localparam int tHigh0 = 3;
  localparam int tHigh1 = 7;
  localparam int tLatch = 40;
  localparam int tInit  = 64;

  localparam int encCredits = 2;   // Encoder holding buffer depth

  // Counter widths derived from the values above
  localparam int phaseBits  = $clog2(tBit);
  localparam int latchBits  = $clog2(tLatch);
  localparam int initBits   = $clog2(tInit);
  localparam int creditBits = $clog2(encCredits + 1);

endpackage

//--- src/pixelRam.sv
`timescale 1ns/1ns

module pixelRam
  import neoPixelPkg::*;
(
  input  logic                  busClk,
  input  logic                  wr,
  input  logic [bufferBits-1:0] wAddr,
  input  logic [7:0]            dIn,
  input  logic [bufferBits-1:0] rAddr,
  output logic [7:0]            dOut
);

  logic [7:0]            mem [bufferEnd+1];
  logic [bufferBits-1:0] rAddrQ;

  // Write port
  always_ff @(posedge busClk) begin
    if (wr) begin
      mem[wAddr] <= dIn;
    end
  end

  // The read address is captured here, so the data shows up one cycle
  // after the streamer drives the index
  always_ff @(posedge busClk) begin
    rAddrQ <= rAddr;
  end

  assign dOut = mem[rAddrQ];   // Data of the address captured on the last edge

endmodule

//--- src/neoPixelRegisters.sv
`timescale 1ns/1ns

module neoPixelRegisters
  import neoPixelPkg::*;
(
  input  logic                  busClk,
  input  logic                  rst,
  input  logic [17:0]           busAddr,
  input  logic [7:0]            busDataIn,
  input  logic                  busWrite,
  input  logic                  busRead,
  output logic [7:0]            busDataOut,

  input  logic [bufferBits-1:0] pixelIx,
  output logic [7:0]            pixelByte,

  input  logic                  streamSyncOf,
  input  logic                  syncStart,
  input  logic                  state,

  output logic [regMaxBits-1:0] regMax,
  output logic                  regCtrlInit,
  output logic                  regCtrlLimit,
  output logic                  regCtrlRun,
  output logic                  regCtrlLoop,
  output logic                  regCtrl32bit,
  output logic                  initSlow,
  input  logic                  initSlowDone
);

  logic [geomBits-1:0]   regWidth;
  logic [geomBits-1:0]   regHeight;
  logic                  bufferSel;
  logic [7:0]            ctrlByte;
  logic                  ramWrite;
  logic [bufferBits-1:0] ramWAddr;
  logic [7:0]            ramWData;

  assign bufferSel = busAddr[17:16] == 2'b00;   // Everything else is register space

  always_comb begin
    ctrlByte            = '0;
    ctrlByte[ctrlInit]  = regCtrlInit;
    ctrlByte[ctrlLimit] = regCtrlLimit;
    ctrlByte[ctrlRun]   = regCtrlRun;
    ctrlByte[ctrlLoop]  = regCtrlLoop;
    ctrlByte[ctrlWide]  = regCtrl32bit;
  end

  pixelRam frameBuffer (
    .busClk (busClk),
    .wr     (ramWrite),
    .wAddr  (ramWAddr),
    .dIn    (ramWData),
    .rAddr  (pixelIx),
    .dOut   (pixelByte)
  );

  // Control registers. Later statements win, so the order below is the priority
  always_ff @(posedge busClk) begin
    if (rst) begin
      regMax       <= '0;
      regWidth     <= '0;
      regHeight    <= '0;
      regCtrlInit  <= 1'b0;
      regCtrlLimit <= 1'b0;
      regCtrlRun   <= 1'b0;
      regCtrlLoop  <= 1'b0;
      regCtrl32bit <= 1'b0;
      initSlow     <= 1'b0;
      ramWrite     <= 1'b0;
    end else begin
      if (streamSyncOf) regCtrlRun <= regCtrlLoop;   // Loop restarts, single frame stops
      if (syncStart) regCtrlRun <= 1'b1;

      // Init wipes the mode bits and keeps the slow reset request up
      if (regCtrlInit) begin
        regCtrlLimit <= 1'b0;
        regCtrlRun   <= 1'b0;
        regCtrlLoop  <= 1'b0;
        regCtrl32bit <= 1'b0;
        initSlow     <= 1'b1;
      end

      if (initSlowDone) begin
        regCtrlInit <= 1'b0;
        initSlow    <= 1'b0;
      end

      ramWrite <= busWrite && bufferSel;

      if (busWrite && !bufferSel) begin
        case (busAddr[3:0])
          regMaxLo:    regMax[7:0] <= busDataIn;
          regMaxHi:    regMax[regMaxBits-1:8] <= busDataIn[regMaxBits-9:0];
          regCtrl: begin
            regCtrlInit  <= busDataIn[ctrlInit];
            regCtrlLimit <= busDataIn[ctrlLimit];
            regCtrlRun   <= busDataIn[ctrlRun];
            regCtrlLoop  <= busDataIn[ctrlLoop];
            regCtrl32bit <= busDataIn[ctrlWide];
          end
          regWidthLo:  regWidth[7:0] <= busDataIn;
          regWidthHi:  regWidth[geomBits-1:8] <= busDataIn[geomBits-9:0];
          regHeightLo: regHeight[7:0] <= busDataIn;
          regHeightHi: regHeight[geomBits-1:8] <= busDataIn[geomBits-9:0];
          default: ;
        endcase
      end
    end
  end

  // Buffer write data and bus read data
  always_ff @(posedge busClk) begin
    ramWAddr <= busAddr[bufferBits-1:0];
    ramWData <= busDataIn;

    if (busRead) begin
      if (bufferSel) begin
        busDataOut <= 8'hFF;   // The frame buffer has no bus read port
      end else begin
        case (busAddr[3:0])
          regMaxLo:    busDataOut <= regMax[7:0];
          regMaxHi:    busDataOut <= 8'(regMax >> 8);
          regCtrl:     busDataOut <= ctrlByte;
          regState:    busDataOut <= {7'b0000000, state};
          regWidthLo:  busDataOut <= regWidth[7:0];
          regWidthHi:  busDataOut <= 8'(regWidth >> 8);
          regHeightLo: busDataOut <= regHeight[7:0];
          regHeightHi: busDataOut <= 8'(regHeight >> 8);
          default: ;   // Unused index keeps the last value
        endcase
      end
    end
  end

  assert property (@(posedge busClk) disable iff (rst) !(busRead && busWrite))
    else $error("busRead and busWrite are high together");

endmodule

//--- src/pixelStreamer.sv
`timescale 1ns/1ns

module pixelStreamer
  import neoPixelPkg::*;
(
  input  logic                  busClk,
  input  logic                  rst,

  input  logic [regMaxBits-1:0] regMax,
  input  logic                  regCtrlLimit,
  input  logic                  regCtrlRun,
  input  logic                  regCtrl32bit,

  output logic [bufferBits-1:0] pixelIx,
  output logic                  byteValid,
  input  logic                  creditReturn,

  output logic                  busy,
  output logic                  streamSyncOf
);

  typedef enum logic [1:0] {
    stIdle,
    stFetch,   // Issue reads while credits last
    stDrain,   // Wait for the encoder to finish every held byte
    stLatch    // Low gap that ends the frame
  } stateType;

  stateType              stateQ;
  logic [bufferBits-1:0] ixQ;
  logic [bufferBits-1:0] lastIx;
  logic [creditBits-1:0] creditsQ;
  logic [latchBits-1:0]  latchCnt;
  logic                  skipByte;
  logic                  lastByte;
  logic                  advance;
  logic                  issue;

  // Frame length, clamped to the buffer when regMax points past its end
  always_comb begin
    if (regCtrlLimit && regMax <= regMaxBits'(bufferEnd)) begin
      lastIx = regMax[bufferBits-1:0];
    end else begin
      lastIx = bufferBits'(bufferEnd);
    end
  end

  assign skipByte = !regCtrl32bit && ixQ[1:0] == 2'b11;   // Alpha byte in 24-bit mode
  assign lastByte = ixQ == lastIx;

  // A skipped byte moves on without a credit
  assign advance = stateQ == stFetch && (skipByte || creditsQ != '0);
  assign issue   = advance && !skipByte;

  assign pixelIx = ixQ;
  assign busy    = stateQ != stIdle;

  // Combinational so run is updated on the same edge that returns to idle
  assign streamSyncOf = stateQ == stLatch && latchCnt == latchBits'(tLatch - 1);

  always_ff @(posedge busClk) begin
    if (rst) begin
      stateQ    <= stIdle;
      ixQ       <= '0;
      creditsQ  <= creditBits'(encCredits);
      latchCnt  <= '0;
      byteValid <= 1'b0;
    end else begin
      byteValid <= issue;   // RAM data lands one cycle after the index
      creditsQ  <= creditsQ - creditBits'(issue) + creditBits'(creditReturn);

      case (stateQ)
        stIdle: begin
          if (regCtrlRun) begin
            ixQ    <= '0;
            stateQ <= stFetch;
          end
        end
        stFetch: begin
          if (advance) begin
            if (lastByte) begin
              stateQ <= stDrain;
            end else begin
              ixQ <= ixQ + 1'b1;
            end
          end
        end
        stDrain: begin
          latchCnt <= '0;
          if (creditsQ == creditBits'(encCredits)) begin
            stateQ <= stLatch;   // Every byte has left the encoder
          end
        end
        stLatch: begin
          if (streamSyncOf) begin
            stateQ <= stIdle;
          end else begin
            latchCnt <= latchCnt + 1'b1;
          end
        end
        default: stateQ <= stIdle;
      endcase
    end
  end

  // The encoder never hands back more credits than it was given
  assert property (@(posedge busClk) disable iff (rst)
    (creditsQ == creditBits'(encCredits)) |-> !creditReturn)
    else $error("Credit returned while the streamer already holds them all");

endmodule

//--- src/bitEncoder.sv
`timescale 1ns/1ns

module bitEncoder
  import neoPixelPkg::*;
(
  input  logic       busClk,
  input  logic       rst,

  input  logic       byteValid,
  input  logic [7:0] byteIn,
  output logic       creditReturn,

  input  logic       initSlow,
  output logic       initSlowDone,

  output logic       dout
);

  logic [7:0]            holdBuf [encCredits];
  logic                  headPtr;
  logic                  tailPtr;
  logic [creditBits-1:0] countQ;
  logic [phaseBits-1:0]  bitPhase;
  logic [2:0]            bitIx;     // MSB goes out first
  logic [phaseBits-1:0]  highTime;
  logic                  bitLast;
  logic                  pop;
  logic [initBits-1:0]   initCnt;
  logic                  initFinished;

  assign tailPtr  = headPtr ^ countQ[0];
  assign highTime = holdBuf[headPtr][bitIx] ? phaseBits'(tHigh1) : phaseBits'(tHigh0);
  assign bitLast  = bitPhase == phaseBits'(tBit - 1);

  // During init the held bytes are flushed one per cycle instead of sent
  assign pop = countQ != '0 && (initSlow || (bitLast && bitIx == 3'd0));

  always_ff @(posedge busClk) begin
    if (byteValid) begin
      holdBuf[tailPtr] <= byteIn;
    end
  end

  always_ff @(posedge busClk) begin
    if (rst) begin
      headPtr      <= 1'b0;
      countQ       <= '0;
      bitPhase     <= '0;
      bitIx        <= 3'd7;
      creditReturn <= 1'b0;
      dout         <= 1'b0;
      initCnt      <= '0;
      initFinished <= 1'b0;
      initSlowDone <= 1'b0;
    end else begin
      creditReturn <= pop;   // One credit per finished byte
      countQ       <= countQ + creditBits'(byteValid) - creditBits'(pop);
      if (pop) headPtr <= ~headPtr;

      if (initSlow || countQ == '0) begin
        bitPhase <= '0;
        bitIx    <= 3'd7;
      end else if (bitLast) begin
        bitPhase <= '0;
        bitIx    <= bitIx - 3'd1;   // Wraps to 7 for the next byte
      end else begin
        bitPhase <= bitPhase + 1'b1;
      end

      dout <= !initSlow && countQ != '0 && bitPhase < highTime;

      // Slow reset timer, armed again only once initSlow drops
      initSlowDone <= 1'b0;
      if (!initSlow) begin
        initCnt      <= '0;
        initFinished <= 1'b0;
      end else if (!initFinished) begin
        if (initCnt == initBits'(tInit - 1)) begin
          initSlowDone <= 1'b1;
          initFinished <= 1'b1;
        end else begin
          initCnt <= initCnt + 1'b1;
        end
      end
    end
  end

  // The streamer must run out of credits before the buffer overflows
  assert property (@(posedge busClk) disable iff (rst)
    (countQ == creditBits'(encCredits)) |-> !byteValid)
    else $error("Byte arrived while the holding buffer is full");

endmodule

//--- src/neoPixelTop.sv
`timescale 1ns/1ns

module neoPixelTop
  import neoPixelPkg::*;
(
  input  logic        busClk,
  input  logic        rst,
  input  logic [17:0] busAddr,
  input  logic [7:0]  busDataIn,
  input  logic        busWrite,
  input  logic        busRead,
  output logic [7:0]  busDataOut,
  input  logic        syncStart,
  output logic        dout
);

  logic [bufferBits-1:0] pixelIx;
  logic [7:0]            pixelByte;
  logic [regMaxBits-1:0] regMax;
  logic                  regCtrlLimit;
  logic                  regCtrlRun;
  logic                  regCtrl32bit;
  logic                  initSlow;
  logic                  initSlowDone;
  logic                  streamSyncOf;
  logic                  busy;
  logic                  byteValid;
  logic                  creditReturn;

  neoPixelRegisters registers (
    .busClk       (busClk),
    .rst          (rst),
    .busAddr      (busAddr),
    .busDataIn    (busDataIn),
    .busWrite     (busWrite),
    .busRead      (busRead),
    .busDataOut   (busDataOut),
    .pixelIx      (pixelIx),
    .pixelByte    (pixelByte),
    .streamSyncOf (streamSyncOf),
    .syncStart    (syncStart),
    .state        (busy),
    .regMax       (regMax),
    .regCtrlInit  (),   // Only read back over the bus
    .regCtrlLimit (regCtrlLimit),
    .regCtrlRun   (regCtrlRun),
    .regCtrlLoop  (),   // Acts through run at frame end
    .regCtrl32bit (regCtrl32bit),
    .initSlow     (initSlow),
    .initSlowDone (initSlowDone)
  );

  pixelStreamer streamer (
    .busClk       (busClk),
    .rst          (rst),
    .regMax       (regMax),
    .regCtrlLimit (regCtrlLimit),
    .regCtrlRun   (regCtrlRun),
    .regCtrl32bit (regCtrl32bit),
    .pixelIx      (pixelIx),
    .byteValid    (byteValid),
    .creditReturn (creditReturn),
    .busy         (busy),
    .streamSyncOf (streamSyncOf)
  );

  bitEncoder encoder (
    .busClk       (busClk),
    .rst          (rst),
    .byteValid    (byteValid),
    .byteIn       (pixelByte),
    .creditReturn (creditReturn),
    .initSlow     (initSlow),
    .initSlowDone (initSlowDone),
    .dout         (dout)
  );

endmodule

//--- test/neoPixelTests.svh
task automatic clearCapture();
  rxBytes.delete();
  framesSeen = 0;
endtask

task automatic waitFrames(input int count);
  while (framesSeen < count) @(posedge busClk);
endtask

// Expected frame from the limit and alpha skip rules
task automatic buildExpected(input int lastIx, input bit wide);
  expBytes.delete();
  for (int i = 0; i <= lastIx; i++) begin
    if (wide || i % 4 != 3) expBytes.push_back(pixelModel[i]);
  end
endtask

// Every captured frame must repeat the expected bytes
task automatic checkFrames(input int count);
  compareValue("decoded byte count", rxBytes.size(), count * expBytes.size());
  if (rxBytes.size() == count * expBytes.size()) begin
    for (int i = 0; i < rxBytes.size(); i++) begin
      compareValue($sformatf("dout byte %0d", i), rxBytes[i], expBytes[i % expBytes.size()]);
    end
  end
endtask

task automatic playLimitedFrame(input bit wide);
  logic [7:0] value;
  clearCapture();
  buildExpected(11, wide);
  writeBus(regAddr(regMaxLo), 8'd11);
  writeBus(regAddr(regMaxHi), 8'd0);
  writeBus(regAddr(regCtrl), ctrlValue(1'b0, 1'b1, 1'b1, 1'b0, wide));
  waitFrames(1);
  checkFrames(1);
  repeat (tLatch) @(posedge busClk);   // The decoder spots the end early in the latch gap
  readBus(regAddr(regCtrl), value);
  compareValue("busDataOut(regCtrl)", value, ctrlValue(1'b0, 1'b1, 1'b0, 1'b0, wide));
  readBus(regAddr(regState), value);
  compareValue("busDataOut(regState)", value, 0);
endtask

task automatic registerReadback();
  logic [3:0] ixList [6];
  logic [7:0] maskList [6];
  logic [7:0] written [6];
  logic [7:0] value;
  logic [7:0] readBack;
  ixList   = '{regMaxLo, regMaxHi, regWidthLo, regWidthHi, regHeightLo, regHeightHi};
  maskList = '{8'hFF, 8'((1 << (regMaxBits - 8)) - 1),
               8'hFF, 8'((1 << (geomBits - 8)) - 1),
               8'hFF, 8'((1 << (geomBits - 8)) - 1)};
  for (int i = 0; i < 6; i++) begin
    randomByte(written[i]);
    writeBus(regAddr(ixList[i]), written[i]);
  end
  for (int i = 0; i < 6; i++) begin
    readBus(regAddr(ixList[i]), readBack);
    compareValue($sformatf("busDataOut(register %0d)", ixList[i]), readBack,
                 written[i] & maskList[i]);
  end
  // Only limit, loop and wide take random values, so nothing starts
  randomByte(value);
  value = value & ctrlValue(1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
  writeBus(regAddr(regCtrl), value);
  readBus(regAddr(regCtrl), readBack);
  compareValue("busDataOut(regCtrl)", readBack, value);
  writeBus(regAddr(regCtrl), 8'h00);
  readBus(regAddr(regState), readBack);
  compareValue("busDataOut(regState)", readBack, 0);
  randomByte(value);
  readBus(pixelAddr(value), readBack);
  compareValue("busDataOut(buffer)", readBack, 8'hFF);
endtask

task automatic limitedWideFrame();
  logic [7:0] value;
  for (int i = 0; i < 16; i++) begin
    randomByte(value);
    pixelModel[i] = value;
    writeBus(pixelAddr(i), value);
  end
  playLimitedFrame(1'b1);
endtask

task automatic limitedNarrowFrame();
  playLimitedFrame(1'b0);
endtask

task automatic loopFrames();
  logic [7:0] value;
  clearCapture();
  buildExpected(11, 1'b1);
  writeBus(regAddr(regCtrl), ctrlValue(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
  waitFrames(2);
  checkFrames(2);
  while (dout !== 1'b1) @(negedge busClk);   // Third frame is on the line
  writeBus(regAddr(regCtrl), ctrlValue(1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
  waitFrames(3);
  repeat (frameCycles) @(posedge busClk);
  compareValue("frames decoded", framesSeen, 3);
  checkFrames(3);
  readBus(regAddr(regCtrl), value);
  compareValue("busDataOut(regCtrl)", value, ctrlValue(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
endtask

task automatic externalStart();
  clearCapture();
  buildExpected(11, 1'b1);
  @(posedge busClk);
  syncStart <= 1'b1;
  @(posedge busClk);
  syncStart <= 1'b0;
  waitFrames(1);
  repeat (frameCycles) @(posedge busClk);
  compareValue("frames decoded", framesSeen, 1);
  checkFrames(1);
endtask

task automatic initReset();
  logic [7:0] value;
  clearCapture();
  buildExpected(11, 1'b1);
  writeBus(regAddr(regCtrl), ctrlValue(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
  readBus(regAddr(regCtrl), value);
  compareValue("busDataOut(regCtrl)", value, ctrlValue(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
  waitFrames(1);
  checkFrames(1);
  clearCapture();
  // Init lands in the latch gap before loop would restart the frame
  writeBus(regAddr(regCtrl), ctrlValue(1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
  repeat (tInit) begin
    @(negedge busClk);
    compareValue("dout during init", dout, 1'b0);
  end
  repeat (8) @(posedge busClk);
  readBus(regAddr(regCtrl), value);
  compareValue("busDataOut(regCtrl) after init", value, 0);
  compareValue("decoded byte count during init", rxBytes.size(), 0);
  playLimitedFrame(1'b1);
endtask

//--- test/neoPixelTb.sv
`timescale 1ns/1ns

module neoPixelTb
  import neoPixelPkg::*;
();

  localparam int frameCycles   = 12 * 8 * tBit + tLatch + 32;   // Twelve-byte frame plus slack
  localparam int timeoutCycles = 14 * frameCycles;

  logic        busClk;
  logic        rst;
  logic [17:0] busAddr;
  logic [7:0]  busDataIn;
  logic        busWrite;
  logic        busRead;
  logic [7:0]  busDataOut;
  logic        syncStart;
  logic        dout;

  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  logic [16:0] lfsrState  = 17'd89558;
  logic [7:0]  pixelModel [16];   // What software wrote into the first buffer bytes
  logic [7:0]  expBytes [$];

  // Serial line decoder state
  logic [7:0]  rxBytes [$];
  logic [7:0]  byteAcc;
  int          framesSeen = 0;
  int          highCnt = 0;
  int          lowCnt = 0;
  int          bitCnt = 0;

  neoPixelTop i_dut (
    .busClk     (busClk),
    .rst        (rst),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .busWrite   (busWrite),
    .busRead    (busRead),
    .busDataOut (busDataOut),
    .syncStart  (syncStart),
    .dout       (dout)
  );

  initial busClk = 1'b0;
  always #4 busClk = ~busClk;

  // Pulse widths are measured on the falling edge, away from where dout changes
  always @(negedge busClk) begin
    if (!rst && dout) begin
      highCnt++;
      lowCnt = 0;
    end else if (!rst) begin
      if (highCnt != 0) begin
        assert (highCnt == tHigh0 || highCnt == tHigh1) else begin
          errorCount++;
          $display("** Error at %0t ns: dout high time = %0d, expected %0d or %0d",
                   $time, highCnt, tHigh0, tHigh1);
        end
        byteAcc = {byteAcc[6:0], highCnt == tHigh1};   // MSB arrives first
        bitCnt++;
        if (bitCnt % 8 == 0) rxBytes.push_back(byteAcc);
        highCnt = 0;
      end
      lowCnt++;
      if (lowCnt == tBit + 1 && bitCnt != 0) begin   // A low stretch longer than a bit
        assert (bitCnt % 8 == 0) else begin
          errorCount++;
          $display("A frame on dout ended after %0d bits, not a whole number of bytes", bitCnt);
        end
        bitCnt = 0;
        framesSeen++;
      end
    end
  end

  always @(posedge busClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Run stopped after %0d cycles because a test never finished", cycleCount);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [16:0] lfsrStep(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};   // x^17 + x^14 + 1
  endfunction

  task automatic randomByte(output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[6:0], lfsrState[0]};
    end
  endtask

  function automatic logic [17:0] regAddr(input logic [3:0] ix);
    return {2'b01, 12'h000, ix};
  endfunction

  function automatic logic [17:0] pixelAddr(input int ix);
    return 18'(ix[bufferBits-1:0]);
  endfunction

  function automatic logic [7:0] ctrlValue(input bit init, limit, run, loop, wide);
    logic [7:0] value;
    value            = '0;
    value[ctrlInit]  = init;
    value[ctrlLimit] = limit;
    value[ctrlRun]   = run;
    value[ctrlLoop]  = loop;
    value[ctrlWide]  = wide;
    return value;
  endfunction

  task automatic writeBus(input logic [17:0] addr, input logic [7:0] data);
    @(posedge busClk);
    busAddr   <= addr;
    busDataIn <= data;
    busWrite  <= 1'b1;
    @(posedge busClk);
    busWrite  <= 1'b0;
  endtask

  task automatic readBus(input logic [17:0] addr, output logic [7:0] data);
    @(posedge busClk);
    busAddr <= addr;
    busRead <= 1'b1;
    @(posedge busClk);
    busRead <= 1'b0;
    @(negedge busClk);   // Read data is registered on the edge that ends the access
    data = busDataOut;
  endtask

  task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  `include "neoPixelTests.svh"

  initial begin
    rst       = 1'b1;
    busAddr   = '0;
    busDataIn = '0;
    busWrite  = 1'b0;
    busRead   = 1'b0;
    syncStart = 1'b0;
    repeat (3) @(posedge busClk);
    rst <= 1'b0;
    @(posedge busClk);

    registerReadback();
    limitedWideFrame();
    limitedNarrowFrame();
    loopFrames();
    externalStart();
    initReset();

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+test
src/neoPixelPkg.sv
src/pixelRam.sv
src/neoPixelRegisters.sv
src/pixelStreamer.sv
src/bitEncoder.sv
src/neoPixelTop.sv
test/neoPixelTb.sv
